// ==== build.f ====
+incdir+rtl
rtl/bomb_pkg.sv
rtl/tile_cell.sv
rtl/blast_spread.sv
rtl/bomb_grid.sv
rtl/bomb_inventory.sv
rtl/game_referee.sv
rtl/bomb_arena.sv
verif/bomb_arena_tb.sv

// ==== Makefile ====
# Verilator flow for the bomb arena testbench

VERILATOR ?= verilator
TOP       ?= bomb_arena_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(shell sed -n '/^[^+]/p' $(FILELIST)) rtl/bomb_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/bomb_arena_tb.sv ====
`timescale 1ns/1ps
`include "bomb_defs.svh"

module bomb_arena_tb;
	import bomb_pkg::*;

	logic                   clk;
	logic                   reset;
	tile_idx_t              p1_cor;
	tile_idx_t              p2_cor;
	logic                   p1_put;
	logic                   p2_put;
	blast_len_t             p1_bomb_len;
	blast_len_t             p2_bomb_len;
	tile_state_t            bomb_tile [`TILE_COUNT];
	logic [`TILE_COUNT-1:0] explode;
	logic [2:0]             bomb_num_p1;
	logic [2:0]             bomb_num_p2;
	game_status_t           game_status;

	logic [15:0]       lfsr;
	int                cycles;
	logic              m_p1w; // referee model
	logic              m_p2w;
	logic              m_over;
	int                m_ctr;
	game_status_t      m_status;
	tile_idx_t         centre;
	tile_idx_t         far_cor;
	logic [1:0]        len;

	bomb_arena bomb_arena_inst (
		.clk        (clk),
		.reset      (reset),
		.p1_cor     (p1_cor),
		.p2_cor     (p2_cor),
		.p1_put     (p1_put),
		.p2_put     (p2_put),
		.p1_bomb_len(p1_bomb_len),
		.p2_bomb_len(p2_bomb_len),
		.bomb_tile  (bomb_tile),
		.explode    (explode),
		.bomb_num_p1(bomb_num_p1),
		.bomb_num_p2(bomb_num_p2),
		.game_status(game_status)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= 20000) begin
			$display("timeout: the run went past 20000 clock cycles without finishing");
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		logic       b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], b};
			r    = {r[6:0], b};
		end
		return r;
	endfunction

	function automatic tile_state_t expected_flame(input int t, input int c, input int l);
		int tr;
		int tc;
		int cr;
		int cc;
		tr = t / 16;
		tc = t % 16;
		cr = c / 16;
		cc = c % 16;
		if (t == c)
			return EXP_CEN;
		if (tr == cr && tc > cc && tc - cc <= l + 1)
			return EXP_RIGHT;
		if (tr == cr && tc < cc && cc - tc <= l + 1)
			return EXP_LEFT;
		if (tc == cc && tr > cr && tr - cr <= l + 1)
			return EXP_DOWN;
		if (tc == cc && tr < cr && cr - tr <= l + 1)
			return EXP_UP;
		return EMPTY;
	endfunction

	function automatic game_status_t expected_status(input logic p1w, input logic p2w,
		input logic over);
		if (over)
			return GAME_OVER;
		if (p1w)
			return P1_WIN;
		if (p2w)
			return P2_WIN;
		return NOT_OVER;
	endfunction

	// compares every cycle once the falling-edge drive has settled
	always @(negedge clk) begin
		#1;
		if (reset) begin
			m_p1w    = 1'b0;
			m_p2w    = 1'b0;
			m_over   = 1'b0;
			m_ctr    = 0;
			m_status = NOT_OVER;
		end else begin
			check_value("game_status", game_status, m_status);
			m_status = expected_status(m_p1w, m_p2w, m_over); // lags the flags by one edge
			if (!(m_p1w || m_p2w) && (explode[p1_cor] || explode[p2_cor])) begin
				if (explode[p1_cor])
					m_p2w = 1'b1;
				else
					m_p1w = 1'b1;
				m_over = 1'b1;
				m_ctr  = 0;
			end else if (m_over) begin
				if (m_ctr == `OVER_TICKS)
					m_over = 1'b0;
				else
					m_ctr = m_ctr + 1;
			end
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		wait_cycles(5);
		check_value("bomb_num_p1", bomb_num_p1, 0);
		check_value("bomb_num_p2", bomb_num_p2, 0);
		check_value("game_status", game_status, NOT_OVER);
		check_tiles_empty();
		reset = 1'b0;
	endtask

	task automatic check_tiles_empty();
		for (int t = 0; t < `TILE_COUNT; t++) begin
			check_value($sformatf("bomb_tile[%0d]", t), bomb_tile[t], EMPTY);
			check_value($sformatf("explode[%0d]", t), explode[t], 0);
		end
	endtask

	task automatic check_cross(input int c, input int l);
		tile_state_t exp_tile;
		for (int t = 0; t < `TILE_COUNT; t++) begin
			exp_tile = expected_flame(t, c, l);
			check_value($sformatf("bomb_tile[%0d]", t), bomb_tile[t], exp_tile);
			check_value($sformatf("explode[%0d]", t), explode[t], exp_tile != EMPTY);
		end
	endtask

	function automatic tile_idx_t far_from(input tile_idx_t c);
		return {c[7:4] + 4'd8, c[3:0] + 4'd8}; // eight rows and columns away
	endfunction

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		p1_cor      = '0;
		p2_cor      = '0;
		p1_put      = 1'b0;
		p2_put      = 1'b0;
		p1_bomb_len = '0;
		p2_bomb_len = '0;
		cycles      = 0;
		lfsr        = 16'(86324);
		apply_reset();

		// both players on one tile, p1 wins it
		p1_cor = 8'h66;
		p2_cor = 8'h66;
		p1_put = 1'b1;
		p2_put = 1'b1;
		wait_cycles(1);
		p2_put = 1'b0;
		check_value("bomb_num_p1", bomb_num_p1, 1);
		check_value("bomb_num_p2", bomb_num_p2, 0);
		check_value("bomb_tile[0x66]", bomb_tile[8'h66], BOMB_UN);
		for (int i = 1; i <= 3; i++) begin
			p1_cor = tile_idx_t'(i * 17); // 0x11, 0x22, 0x33
			wait_cycles(1);
			check_value("bomb_num_p1", bomb_num_p1, i + 1);
			check_value("bomb_tile", bomb_tile[i * 17], BOMB_UN);
		end
		p1_cor = 8'h44; // no slot left
		wait_cycles(1);
		p1_put = 1'b0;
		check_value("bomb_num_p1", bomb_num_p1, 4);
		check_value("bomb_tile[0x44]", bomb_tile[8'h44], EMPTY);
		p2_put = 1'b1; // occupied tile
		wait_cycles(1);
		p2_put = 1'b0;
		check_value("bomb_num_p2", bomb_num_p2, 0);
		p1_cor = 8'hee;
		p2_cor = 8'hee;
		wait_cycles(100);
		check_value("bomb_num_p1", bomb_num_p1, 0);
		check_value("bomb_num_p2", bomb_num_p2, 0);
		check_tiles_empty();

		// single blasts, corners and edges first
		for (int i = 0; i < 16; i++) begin
			case (i)
				0: centre = 8'h00;
				1: centre = 8'h0f;
				2: centre = 8'hf0;
				3: centre = 8'hff;
				4: centre = 8'h07;
				5: centre = 8'h70;
				6: centre = 8'h7f;
				7: centre = 8'hf7;
				default: centre = rand_bits(8);
			endcase
			len         = 2'(i % 4);
			far_cor     = far_from(centre);
			p1_bomb_len = len;
			p2_bomb_len = 2'(rand_bits(2));
			p1_cor      = centre;
			p2_cor      = far_cor;
			p1_put      = 1'b1;
			wait_cycles(1);
			p1_put = 1'b0;
			p1_cor = far_cor;
			wait_cycles(60);
			check_value("centre tile", bomb_tile[centre], BOMB_UN);
			wait_cycles(1);
			check_value("centre tile", bomb_tile[centre], EXP_CEN);
			wait_cycles(1);
			check_cross(centre, len);
			wait_cycles(31);
			check_tiles_empty();
		end

		// chain, a p2 bomb inside the right arm of a p1 bomb
		p1_bomb_len = 2'd0;
		p2_bomb_len = 2'd3;
		p1_cor      = 8'h84;
		p2_cor      = 8'h0f;
		p1_put      = 1'b1;
		wait_cycles(1);
		p1_put = 1'b0;
		p1_cor = 8'h0f;
		wait_cycles(9);
		p2_cor = 8'h85;
		p2_put = 1'b1;
		wait_cycles(1);
		p2_put = 1'b0;
		p2_cor = 8'h0f;
		wait_cycles(51);
		check_value("first centre", bomb_tile[8'h84], EXP_CEN);
		check_value("second bomb", bomb_tile[8'h85], BOMB_UN);
		wait_cycles(1);
		for (int t = 0; t < `TILE_COUNT; t++)
			check_value($sformatf("bomb_tile[%0d]", t), bomb_tile[t],
				(t == 8'h85) ? EXP_CEN : expected_flame(t, 8'h84, 0));
		wait_cycles(1);
		for (int t = 0; t < `TILE_COUNT; t++)
			check_value($sformatf("bomb_tile[%0d]", t), bomb_tile[t],
				(t == 8'h85) ? EXP_CEN : (expected_flame(t, 8'h84, 0) != EMPTY) ?
				expected_flame(t, 8'h84, 0) : expected_flame(t, 8'h85, 3));
		wait_cycles(32);
		check_tiles_empty();

		// p1 caught in a p2 blast, then p2 hit later
		apply_reset();
		p2_bomb_len = 2'd1;
		p1_cor      = 8'h00;
		p2_cor      = 8'h88;
		p2_put      = 1'b1;
		wait_cycles(1);
		p2_put = 1'b0;
		p2_cor = 8'h00;
		p1_cor = 8'h89;
		wait_cycles(64);
		check_value("game_status", game_status, GAME_OVER);
		wait_cycles(60);
		check_value("game_status", game_status, GAME_OVER);
		wait_cycles(1);
		check_value("game_status", game_status, P2_WIN);
		p1_cor = 8'h10; // up arm reaches p2 at tile 0
		p1_put = 1'b1;
		wait_cycles(1);
		p1_put = 1'b0;
		p1_cor = 8'hcc;
		wait_cycles(100);
		check_value("game_status", game_status, P2_WIN);

		// mirrored case
		apply_reset();
		p1_bomb_len = 2'd1;
		p2_cor      = 8'h00;
		p1_cor      = 8'h88;
		p1_put      = 1'b1;
		wait_cycles(1);
		p1_put = 1'b0;
		p1_cor = 8'h00;
		p2_cor = 8'h89;
		wait_cycles(64);
		check_value("game_status", game_status, GAME_OVER);
		wait_cycles(61);
		check_value("game_status", game_status, P1_WIN);
		wait_cycles(40);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== rtl/bomb_arena.sv ====
`timescale 1ns/1ps
`include "bomb_defs.svh"

module bomb_arena (
	input  logic                   clk,
	input  logic                   reset,
	input  bomb_pkg::tile_idx_t    p1_cor,
	input  bomb_pkg::tile_idx_t    p2_cor,
	input  logic                   p1_put,
	input  logic                   p2_put,
	input  bomb_pkg::blast_len_t   p1_bomb_len,
	input  bomb_pkg::blast_len_t   p2_bomb_len,
	output bomb_pkg::tile_state_t  bomb_tile [`TILE_COUNT],
	output logic [`TILE_COUNT-1:0] explode,
	output logic [2:0]             bomb_num_p1,
	output logic [2:0]             bomb_num_p2,
	output bomb_pkg::game_status_t game_status
);

	logic p1_has_slot;
	logic p2_has_slot;
	logic p1_placed; // one strobe per accepted put
	logic p2_placed;

	bomb_grid bomb_grid_inst (
		.clk        (clk),
		.reset      (reset),
		.p1_cor     (p1_cor),
		.p2_cor     (p2_cor),
		.p1_put     (p1_put),
		.p2_put     (p2_put),
		.p1_has_slot(p1_has_slot),
		.p2_has_slot(p2_has_slot),
		.p1_bomb_len(p1_bomb_len),
		.p2_bomb_len(p2_bomb_len),
		.bomb_tile  (bomb_tile),
		.explode    (explode),
		.p1_placed  (p1_placed),
		.p2_placed  (p2_placed)
	);

	bomb_inventory p1_inventory_inst (
		.clk     (clk),
		.reset   (reset),
		.placed  (p1_placed),
		.has_slot(p1_has_slot),
		.bomb_num(bomb_num_p1)
	);

	bomb_inventory p2_inventory_inst (
		.clk     (clk),
		.reset   (reset),
		.placed  (p2_placed),
		.has_slot(p2_has_slot),
		.bomb_num(bomb_num_p2)
	);

	game_referee game_referee_inst (
		.clk        (clk),
		.reset      (reset),
		.explode    (explode),
		.p1_cor     (p1_cor),
		.p2_cor     (p2_cor),
		.game_status(game_status)
	);

endmodule

// ==== rtl/game_referee.sv ====
`timescale 1ns/1ps
`include "bomb_defs.svh"

module game_referee (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`TILE_COUNT-1:0] explode,
	input  bomb_pkg::tile_idx_t    p1_cor,
	input  bomb_pkg::tile_idx_t    p2_cor,
	output bomb_pkg::game_status_t game_status
);
	import bomb_pkg::*;

	logic              p1_win;
	logic              p2_win;
	logic              game_over;
	logic [`CTR_W-1:0] over_ctr;
	logic              decided;
	logic              any_hit;

	assign decided = p1_win || p2_win;
	assign any_hit = explode[p1_cor] || explode[p2_cor];

	// first hit decides, a hit on p1 checked before p2
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			p1_win <= 1'b0;
			p2_win <= 1'b0;
		end else if (!decided) begin
			if (explode[p1_cor])
				p2_win <= 1'b1;
			else if (explode[p2_cor])
				p1_win <= 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			game_over <= 1'b0;
			over_ctr  <= '0;
		end else if (!decided && any_hit) begin
			game_over <= 1'b1; // same edge as the win flag
			over_ctr  <= '0;
		end else if (game_over) begin
			if (over_ctr >= `CTR_W'(`OVER_TICKS)) begin
				game_over <= 1'b0;
				over_ctr  <= '0;
			end else begin
				over_ctr <= over_ctr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			game_status <= NOT_OVER;
		else if (game_over)
			game_status <= GAME_OVER;
		else if (p1_win)
			game_status <= P1_WIN;
		else if (p2_win)
			game_status <= P2_WIN;
		else
			game_status <= NOT_OVER;
	end

endmodule

// ==== rtl/bomb_inventory.sv ====
`timescale 1ns/1ps
`include "bomb_defs.svh"

module bomb_inventory (
	input  logic       clk,
	input  logic       reset,
	input  logic       placed,
	output logic       has_slot,
	output logic [2:0] bomb_num
);

	logic [`SLOT_COUNT-1:0] occ;
	logic [`SLOT_COUNT-1:0] occ_next;
	logic [`CTR_W-1:0]      slot_ctr [`SLOT_COUNT];
	logic [`CTR_W-1:0]      slot_ctr_next [`SLOT_COUNT];

	always_comb begin
		logic filled;
		filled   = 1'b0;
		occ_next = occ;
		for (int s = 0; s < `SLOT_COUNT; s++) begin
			slot_ctr_next[s] = slot_ctr[s];
			if (occ[s]) begin
				if (slot_ctr[s] >= `CTR_W'(`SLOT_TICKS)) begin
					occ_next[s]      = 1'b0; // hold time over
					slot_ctr_next[s] = '0;
				end else begin
					slot_ctr_next[s] = slot_ctr[s] + 1'b1;
				end
			end else if (placed && !filled) begin
				occ_next[s]      = 1'b1; // lowest free slot takes the bomb
				slot_ctr_next[s] = '0;
				filled           = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			occ <= '0;
			for (int s = 0; s < `SLOT_COUNT; s++)
				slot_ctr[s] <= '0;
		end else begin
			occ <= occ_next;
			for (int s = 0; s < `SLOT_COUNT; s++)
				slot_ctr[s] <= slot_ctr_next[s];
		end
	end

	assign has_slot = ~&occ;
	assign bomb_num = 3'($countones(occ));

endmodule

// ==== rtl/bomb_grid.sv ====
`timescale 1ns/1ps
`include "bomb_defs.svh"

module bomb_grid (
	input  logic                   clk,
	input  logic                   reset,
	input  bomb_pkg::tile_idx_t    p1_cor,
	input  bomb_pkg::tile_idx_t    p2_cor,
	input  logic                   p1_put,
	input  logic                   p2_put,
	input  logic                   p1_has_slot,
	input  logic                   p2_has_slot,
	input  bomb_pkg::blast_len_t   p1_bomb_len,
	input  bomb_pkg::blast_len_t   p2_bomb_len,
	output bomb_pkg::tile_state_t  bomb_tile [`TILE_COUNT],
	output logic [`TILE_COUNT-1:0] explode,
	output logic                   p1_placed,
	output logic                   p2_placed
);
	import bomb_pkg::*;

	logic [`TILE_COUNT-1:0] igniting;
	logic [`TILE_COUNT-1:0] owner_bits;
	logic [`TILE_COUNT-1:0] flame_req;
	tile_state_t            flame_dir [`TILE_COUNT];

	// a put needs a free slot and a tile that is empty and not about to burn
	assign p1_placed = p1_put && p1_has_slot && (bomb_tile[p1_cor] == EMPTY)
		&& !flame_req[p1_cor];
	assign p2_placed = p2_put && p2_has_slot && (bomb_tile[p2_cor] == EMPTY)
		&& !flame_req[p2_cor] && !(p1_placed && (p1_cor == p2_cor)); // p1 first

	for (genvar t = 0; t < `TILE_COUNT; t++) begin : g_cell
		logic hit1;
		logic hit2;

		assign hit1 = p1_placed && (p1_cor == tile_idx_t'(t));
		assign hit2 = p2_placed && (p2_cor == tile_idx_t'(t));

		tile_cell tile_cell_inst (
			.clk        (clk),
			.reset      (reset),
			.place      (hit1 || hit2),
			.place_owner(hit1 ? OWNER_P1 : OWNER_P2),
			.flame_req  (flame_req[t]),
			.flame_dir  (flame_dir[t]),
			.state      (bomb_tile[t]),
			.owner      (owner_bits[t]),
			.igniting   (igniting[t])
		);

		assign explode[t] = (bomb_tile[t] >= EXP_UP);
	end

	blast_spread blast_spread_inst (
		.igniting   (igniting),
		.owner      (owner_bits),
		.p1_bomb_len(p1_bomb_len),
		.p2_bomb_len(p2_bomb_len),
		.flame_req  (flame_req),
		.flame_dir  (flame_dir)
	);

endmodule

// ==== rtl/blast_spread.sv ====
`timescale 1ns/1ps
`include "bomb_defs.svh"

module blast_spread (
	input  logic [`TILE_COUNT-1:0] igniting,
	input  logic [`TILE_COUNT-1:0] owner,
	input  bomb_pkg::blast_len_t   p1_bomb_len,
	input  bomb_pkg::blast_len_t   p2_bomb_len,
	output logic [`TILE_COUNT-1:0] flame_req,
	output bomb_pkg::tile_state_t  flame_dir [`TILE_COUNT]
);
	import bomb_pkg::*;

	logic [2:0] reach [`TILE_COUNT]; // arm length of a centre, 1 to 4

	for (genvar c = 0; c < `TILE_COUNT; c++) begin : g_reach
		assign reach[c] = (owner_t'(owner[c]) == OWNER_P1) ?
			{1'b0, p1_bomb_len} + 3'd1 : {1'b0, p2_bomb_len} + 3'd1;
	end

	// each target looks outward for a centre whose arm covers it
	for (genvar t = 0; t < `TILE_COUNT; t++) begin : g_target
		localparam int ROW = t / `GRID_COLS;
		localparam int COL = t % `GRID_COLS;

		tile_state_t dir;

		// arms are scanned in rising code order so the higher code wins a clash
		always_comb begin
			tile_idx_t src;
			dir = EMPTY;
			for (int d = 1; d <= `MAX_REACH; d++) begin
				src = tile_idx_t'(t + d * `GRID_COLS); // centre below
				if (ROW + d < `GRID_ROWS && igniting[src] && int'(reach[src]) >= d)
					dir = EXP_UP;
			end
			for (int d = 1; d <= `MAX_REACH; d++) begin
				src = tile_idx_t'(t - d * `GRID_COLS); // centre above
				if (ROW - d >= 0 && igniting[src] && int'(reach[src]) >= d)
					dir = EXP_DOWN;
			end
			for (int d = 1; d <= `MAX_REACH; d++) begin
				src = tile_idx_t'(t + d); // centre to the right, same row
				if (COL + d < `GRID_COLS && igniting[src] && int'(reach[src]) >= d)
					dir = EXP_LEFT;
			end
			for (int d = 1; d <= `MAX_REACH; d++) begin
				src = tile_idx_t'(t - d); // centre to the left, same row
				if (COL - d >= 0 && igniting[src] && int'(reach[src]) >= d)
					dir = EXP_RIGHT;
			end
		end

		assign flame_dir[t] = dir;
		assign flame_req[t] = (dir != EMPTY);
	end

endmodule

// ==== rtl/tile_cell.sv ====
`timescale 1ns/1ps
`include "bomb_defs.svh"

module tile_cell (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  place,
	input  bomb_pkg::owner_t      place_owner,
	input  logic                  flame_req,
	input  bomb_pkg::tile_state_t flame_dir,
	output bomb_pkg::tile_state_t state,
	output bomb_pkg::owner_t      owner,
	output logic                  igniting
);
	import bomb_pkg::*;

	logic [`CTR_W-1:0] ctr;
	logic [`CTR_W-1:0] ctr_next;
	tile_state_t       state_next;

	always_comb begin
		state_next = state;
		ctr_next   = ctr + 1'b1;
		case (state)
			EMPTY: begin
				ctr_next = '0;
				if (place)
					state_next = BOMB_UN;
				else if (flame_req)
					state_next = flame_dir; // arm of a neighbouring blast
			end
			BOMB_UN: begin
				// a flame reaching an armed bomb sets it off at once
				if (flame_req || ctr >= `CTR_W'(`FUSE_TICKS)) begin
					state_next = EXP_CEN;
					ctr_next   = '0;
				end
			end
			default: begin // any flame code, further requests are ignored
				if (ctr >= `CTR_W'(`FLAME_TICKS)) begin
					state_next = EMPTY;
					ctr_next   = '0;
				end
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= EMPTY;
			ctr   <= '0;
		end else begin
			state <= state_next;
			ctr   <= ctr_next;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			owner <= OWNER_P1;
		else if (place)
			owner <= place_owner; // kept through a chained ignition
	end

	assign igniting = (state == EXP_CEN) && (ctr == '0); // first centre cycle only

endmodule

// ==== rtl/bomb_pkg.sv ====
package bomb_pkg;

	// a tile is on fire when its code is EXP_UP or above
	typedef enum logic [2:0] {
		EMPTY     = 3'd0,
		BOMB_UN   = 3'd2,
		EXP_UP    = 3'd3,
		EXP_DOWN  = 3'd4,
		EXP_LEFT  = 3'd5,
		EXP_RIGHT = 3'd6,
		EXP_CEN   = 3'd7
	} tile_state_t;

	typedef logic [7:0] tile_idx_t; // row * 16 + col

	typedef enum logic {
		OWNER_P1 = 1'b0,
		OWNER_P2 = 1'b1
	} owner_t;

	typedef logic [1:0] blast_len_t; // arm reach minus one

	typedef enum logic [1:0] {
		NOT_OVER  = 2'd0,
		GAME_OVER = 2'd1,
		P1_WIN    = 2'd2,
		P2_WIN    = 2'd3
	} game_status_t;

endpackage

// ==== rtl/bomb_defs.svh ====
`ifndef BOMB_DEFS_SVH
`define BOMB_DEFS_SVH

// arena geometry
`define GRID_COLS 16
`define GRID_ROWS 16
`define TILE_COUNT 256

// timer limits, a phase lasts limit plus one cycles
`define FUSE_TICKS 60
`define FLAME_TICKS 30
`define SLOT_TICKS 60
`define OVER_TICKS 60

// bombs a player may have on the field at once
`define SLOT_COUNT 4

// width of every tick counter
`define CTR_W 6

// longest arm of a cross, in tiles
`define MAX_REACH 4

`endif
